// ==== tb.f ====
+incdir+.
common_pkg.sv
video_ram.sv
vga_timing.sv
pixel_pipe.sv
video_regs.sv
video_subsystem.sv
video_checker.sv
tb_top.sv

// ==== tb_top.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module tb_top;

    import common_pkg::*;

    // up to the second vsync is about 2 frames of 168000 cpu cycles
    localparam int TIMEOUT_CYCLES = 450000;
    localparam int MODE_OFF       = 0;
    localparam int MODE_PIC       = 1;
    localparam int MODE_BORDER    = 2;

    logic        cpu_clk = 1'b0;
    logic        pxl_clk = 1'b0;
    logic        rst;
    word_t       cpu_addr;
    word_t       cpu_wdata;
    byte_mask_t  cpu_mask;
    word_t       cpu_rdata;
    color4_t     vga_r;
    color4_t     vga_g;
    color4_t     vga_b;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        vga_de;

    byte_t       ram_model [0:4095];
    rgb332_t     border_model;
    logic        en_model;
    word_t       lcg_state = 32'd95767;
    int unsigned value_errors;
    int unsigned cycles;
    int unsigned frames_seen;
    int unsigned pic_pixels;
    int unsigned border_pixels;
    int          check_mode;
    int          line_mode;
    int          px_x;
    int          px_y;
    bit          de_q;

    always #50 cpu_clk = ~cpu_clk;
    always #20 pxl_clk = ~pxl_clk;

    video_subsystem dut0 (
        .cpu_clk_i        (cpu_clk),
        .rst_i            (rst),
        .cpu_addr_i       (cpu_addr),
        .cpu_write_data_i (cpu_wdata),
        .cpu_write_mask_i (cpu_mask),
        .cpu_read_data_o  (cpu_rdata),
        .pxl_clk_i        (pxl_clk),
        .vga_r_o          (vga_r),
        .vga_g_o          (vga_g),
        .vga_b_o          (vga_b),
        .vga_hsync_o      (vga_hsync),
        .vga_vsync_o      (vga_vsync),
        .vga_de_o         (vga_de)
    );

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rgb332 to {r, g, b}, top bits replicated into the low bits
    function automatic logic [11:0] expand_rgb(input rgb332_t p);
        return {p[7:5], p[7], p[4:2], p[4], p[1:0], p[1:0]};
    endfunction

    function automatic word_t model_word(input word_t addr);
        int a;
        a = {addr[11:2], 2'b00};
        return {ram_model[a + 3], ram_model[a + 2], ram_model[a + 1], ram_model[a]};
    endfunction

    function automatic void apply_write(input word_t addr, input word_t data,
                                        input byte_mask_t mask);
        int a;
        a = {addr[11:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                ram_model[a + k] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic word_t expected_ctrl();
        return {16'b0, border_model, 7'b0, en_model};
    endfunction

    task automatic write_word(input word_t addr, input word_t data, input byte_mask_t mask);
        @(posedge cpu_clk);
        cpu_addr  <= addr;
        cpu_wdata <= data;
        cpu_mask  <= mask;
    endtask

    // data is registered, so look one edge after the address
    task automatic check_read(input word_t addr, input word_t exp, input string what);
        @(posedge cpu_clk);
        cpu_addr <= addr;
        cpu_mask <= '0;
        @(posedge cpu_clk);
        @(negedge cpu_clk);
        assert (cpu_rdata === exp) else begin
            value_errors++;
            $display("FAIL %0t: %s at %h read %h, expected %h",
                     $time, what, addr, cpu_rdata, exp);
        end
    endtask

    task automatic finish_run();
        int unsigned assert_errors;
        assert_errors = dut0.chk0.fail_count;
        assert (pic_pixels == `H_ACTIVE * `V_ACTIVE && border_pixels > 0) else begin
            value_errors++;
            $display("FAIL %0t: pixel checks covered %0d picture and %0d border pixels",
                     $time, pic_pixels, border_pixels);
        end
        $display("errors: %0d value, %0d assertion", value_errors, assert_errors);
        if (value_errors == 0 && assert_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // raster position tracked from data enable alone
    always @(negedge pxl_clk) begin
        logic [11:0] got;
        logic [11:0] exp;
        got = {vga_r, vga_g, vga_b};
        exp = '0;
        if (vga_vsync === 1'b0) begin
            px_x = 0;
            px_y = 0;
        end else if (vga_de === 1'b1) begin
            if (!de_q) begin
                line_mode = check_mode;
            end
            if (line_mode == MODE_PIC) begin
                exp = expand_rgb(ram_model[(px_y / `PIC_SCALE) * `PIC_W + px_x / `PIC_SCALE]);
                pic_pixels++;
            end else if (line_mode == MODE_BORDER) begin
                exp = expand_rgb(border_model);
                border_pixels++;
            end
            if (line_mode != MODE_OFF) begin
                assert (got === exp) else begin
                    value_errors++;
                    $display("FAIL %0t: pixel (%0d,%0d) is %h, expected %h",
                             $time, px_x, px_y, got, exp);
                end
            end
            px_x++;
        end else if (de_q) begin
            px_x = 0;
            px_y++;
        end
        de_q = (vga_de === 1'b1);
    end

    always @(posedge cpu_clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cpu cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        word_t      addr;
        word_t      data;
        word_t      r;
        byte_mask_t mask;
        for (int i = 0; i < 4096; i++) begin
            ram_model[i] = '0;
        end
        rst          = 1'b1;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_mask     = '0;
        check_mode   = MODE_OFF;
        line_mode    = MODE_OFF;
        en_model     = 1'b0;
        border_model = '0;
        repeat (4) @(posedge cpu_clk);
        rst <= 1'b0;

        check_read(`REG_CTRL, expected_ctrl(), "ctrl after reset");
        check_read(`REG_STATUS, '0, "status after reset");

        // display off with a random border
        data = next_rand();
        border_model = data[15:8];
        write_word(`REG_CTRL, {data[31:1], 1'b0}, 4'b1111);
        check_read(`REG_CTRL, expected_ctrl(), "ctrl readback");
        write_word(`REG_STATUS, next_rand(), 4'b1111);
        check_read(`REG_STATUS, '0, "status after write");
        check_read(`REG_CTRL, expected_ctrl(), "ctrl after status write");
        write_word(32'h1ffc, next_rand(), 4'b1111);
        check_read(32'h0000, model_word(32'h0000), "ram after ctrl write");
        check_read(32'h0004, model_word(32'h0004), "ram after status write");
        check_read(32'h0ffc, model_word(32'h0ffc), "ram after register write");
        repeat (2) @(posedge cpu_clk);
        check_mode = MODE_BORDER;

        for (int i = 0; i < 1024; i++) begin
            data = next_rand();
            write_word(i * 4, data, 4'b1111);
            apply_write(i * 4, data, 4'b1111);
        end
        // low address bits are random and must be ignored
        for (int i = 0; i < 300; i++) begin
            r    = next_rand();
            addr = {20'b0, r[27:16]};
            mask = r[31:28];
            data = next_rand();
            write_word(addr, data, mask);
            apply_write(addr, data, mask);
            check_read(addr, model_word(addr), "masked ram write");
        end
        for (int i = 0; i < 1024; i++) begin
            check_read(i * 4, model_word(i * 4), "ram readback");
        end
        check_read(`REG_CTRL, expected_ctrl(), "ctrl after ram writes");
        check_read(`REG_STATUS, '0, "status before first vsync");

        @(negedge vga_vsync);
        check_mode = MODE_OFF;
        frames_seen++;
        repeat (4) @(posedge cpu_clk);
        check_read(`REG_STATUS, frames_seen, "frame count");
        en_model = 1'b1;
        write_word(`REG_CTRL, {16'b0, border_model, 8'h01}, 4'b0011);
        check_read(`REG_CTRL, expected_ctrl(), "ctrl enable");
        check_mode = MODE_PIC;

        @(negedge vga_vsync);
        check_mode = MODE_OFF;
        frames_seen++;
        repeat (4) @(posedge cpu_clk);
        check_read(`REG_STATUS, frames_seen, "frame count");
        finish_run();
    end

endmodule

`default_nettype wire

// ==== video_checker.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module video_checker (
    input wire logic               pxl_clk_i,
    input wire logic               pxl_rst_i,
    input wire common_pkg::color4_t red_i,
    input wire common_pkg::color4_t green_i,
    input wire common_pkg::color4_t blue_i,
    input wire logic               hsync_i,
    input wire logic               vsync_i,
    input wire logic               de_i
);

    import common_pkg::*;

    bit          live;
    bit          hs_q;
    bit          vs_q;
    bit          h_armed;
    bit          v_armed;
    int unsigned h_since;
    int unsigned h_low;
    int unsigned v_since;
    int unsigned v_low;
    int unsigned fail_count;
    logic        h_fall;
    logic        h_rise;
    logic        v_fall;
    logic        v_rise;

    // outputs are defined once the synchronised reset has been seen low
    always_ff @(posedge pxl_clk_i) begin
        live <= (pxl_rst_i === 1'b0);
    end

    assign h_fall = hs_q && !hsync_i;
    assign h_rise = !hs_q && hsync_i;
    assign v_fall = vs_q && !vsync_i;
    assign v_rise = !vs_q && vsync_i;

    // clocks since last falling edge, and length of the current low run
    always_ff @(posedge pxl_clk_i) begin
        if (!live) begin
            hs_q    <= 1'b1;
            vs_q    <= 1'b1;
            h_armed <= 1'b0;
            v_armed <= 1'b0;
            h_since <= 0;
            v_since <= 0;
            h_low   <= 0;
            v_low   <= 0;
        end else begin
            hs_q  <= hsync_i;
            vs_q  <= vsync_i;
            h_low <= hsync_i ? 0 : h_low + 1;
            v_low <= vsync_i ? 0 : v_low + 1;
            if (h_fall) begin
                h_since <= 1;
                h_armed <= 1'b1;
            end else begin
                h_since <= h_since + 1;
            end
            if (v_fall) begin
                v_since <= 1;
                v_armed <= 1'b1;
            end else begin
                v_since <= v_since + 1;
            end
        end
    end

    hsync_width: assert property (@(posedge pxl_clk_i) disable iff (!live)
        h_rise && h_armed |-> h_low == `H_SYNC)
        else begin
            fail_count++;
            $error("hsync low for %0d pixel clocks", h_low);
        end

    hsync_period: assert property (@(posedge pxl_clk_i) disable iff (!live)
        h_fall && h_armed |-> h_since == `H_TOTAL)
        else begin
            fail_count++;
            $error("hsync period of %0d pixel clocks", h_since);
        end

    vsync_width: assert property (@(posedge pxl_clk_i) disable iff (!live)
        v_rise && v_armed |-> v_low == `V_SYNC * `H_TOTAL)
        else begin
            fail_count++;
            $error("vsync low for %0d pixel clocks", v_low);
        end

    vsync_period: assert property (@(posedge pxl_clk_i) disable iff (!live)
        v_fall && v_armed |-> v_since == `V_TOTAL * `H_TOTAL)
        else begin
            fail_count++;
            $error("vsync period of %0d pixel clocks", v_since);
        end

    de_outside_sync: assert property (@(posedge pxl_clk_i) disable iff (!live)
        de_i |-> hsync_i && vsync_i)
        else begin
            fail_count++;
            $error("data enable high during a sync pulse");
        end

    // blanking must be black
    blank_black: assert property (@(posedge pxl_clk_i) disable iff (!live)
        !de_i |-> (red_i == '0) && (green_i == '0) && (blue_i == '0))
        else begin
            fail_count++;
            $error("colour not zero while data enable is low");
        end

endmodule

bind video_subsystem video_checker chk0 (
    .pxl_clk_i (pxl_clk_i),
    .pxl_rst_i (pxl_rst),
    .red_i     (vga_r_o),
    .green_i   (vga_g_o),
    .blue_i    (vga_b_o),
    .hsync_i   (vga_hsync_o),
    .vsync_i   (vga_vsync_o),
    .de_i      (vga_de_o)
);

`default_nettype wire

// ==== video_subsystem.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module video_subsystem (
    // cpu bus
    input  wire logic                   cpu_clk_i,
    input  wire logic                   rst_i,
    input  wire common_pkg::word_t      cpu_addr_i,
    input  wire common_pkg::word_t      cpu_write_data_i,
    input  wire common_pkg::byte_mask_t cpu_write_mask_i,
    output common_pkg::word_t           cpu_read_data_o,

    // vga
    input  wire logic                   pxl_clk_i,
    output common_pkg::color4_t         vga_r_o,
    output common_pkg::color4_t         vga_g_o,
    output common_pkg::color4_t         vga_b_o,
    output logic                        vga_hsync_o,
    output logic                        vga_vsync_o,
    output logic                        vga_de_o
);

    import common_pkg::*;

    logic       reg_sel;
    logic       reg_sel_q;
    byte_mask_t ram_mask;
    word_t      ram_rd_data;
    word_t      reg_rd_data;

    logic       pxl_rst;
    coord_t     x;
    coord_t     y;
    logic       active;
    logic       hsync;
    logic       vsync;
    logic       frame_start;
    logic       disp_en;
    rgb332_t    border;
    pxl_addr_t  ram_addr;
    byte_t      ram_data;

    assign reg_sel  = cpu_addr_i[`REG_SEL_BIT];
    assign ram_mask = reg_sel ? 4'b0000 : cpu_write_mask_i;

    // aligns select with the one-cycle read data
    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            reg_sel_q <= 1'b0;
        end else begin
            reg_sel_q <= reg_sel;
        end
    end

    assign cpu_read_data_o = reg_sel_q ? reg_rd_data : ram_rd_data;

    video_ram ram0 (
        .cpu_clk_i        (cpu_clk_i),
        .rst_i            (rst_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_write_data_i (cpu_write_data_i),
        .cpu_write_mask_i (ram_mask),
        .cpu_read_data_o  (ram_rd_data),
        .pxl_clk_i        (pxl_clk_i),
        .pxl_rst_i        (pxl_rst),
        .pxl_addr_i       (ram_addr),
        .pxl_data_o       (ram_data)
    );

    vga_timing timing0 (
        .pxl_clk_i     (pxl_clk_i),
        .rst_i         (rst_i),
        .pxl_rst_o     (pxl_rst),
        .x_o           (x),
        .y_o           (y),
        .active_o      (active),
        .hsync_o       (hsync),
        .vsync_o       (vsync),
        .frame_start_o (frame_start)
    );

    pixel_pipe pipe0 (
        .pxl_clk_i   (pxl_clk_i),
        .pxl_rst_i   (pxl_rst),
        .x_i         (x),
        .y_i         (y),
        .active_i    (active),
        .hsync_i     (hsync),
        .vsync_i     (vsync),
        .disp_en_i   (disp_en),
        .border_i    (border),
        .ram_addr_o  (ram_addr),
        .ram_data_i  (ram_data),
        .vga_r_o     (vga_r_o),
        .vga_g_o     (vga_g_o),
        .vga_b_o     (vga_b_o),
        .vga_hsync_o (vga_hsync_o),
        .vga_vsync_o (vga_vsync_o),
        .vga_de_o    (vga_de_o)
    );

    video_regs regs0 (
        .cpu_clk_i     (cpu_clk_i),
        .rst_i         (rst_i),
        .wr_mask_i     (cpu_write_mask_i),
        .wr_data_i     (cpu_write_data_i),
        .reg_addr_i    (cpu_addr_i),
        .reg_sel_i     (reg_sel),
        .rd_data_o     (reg_rd_data),
        .pxl_clk_i     (pxl_clk_i),
        .pxl_rst_i     (pxl_rst),
        .frame_start_i (frame_start),
        .disp_en_o     (disp_en),
        .border_o      (border)
    );

endmodule

`default_nettype wire

// ==== video_regs.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module video_regs (
    // cpu side
    input  wire logic                   cpu_clk_i,
    input  wire logic                   rst_i,
    input  wire common_pkg::byte_mask_t wr_mask_i,
    input  wire common_pkg::word_t      wr_data_i,
    input  wire common_pkg::word_t      reg_addr_i,
    input  wire logic                   reg_sel_i,
    output common_pkg::word_t           rd_data_o,

    // pixel side
    input  wire logic                   pxl_clk_i,
    input  wire logic                   pxl_rst_i,
    input  wire logic                   frame_start_i,
    output logic                        disp_en_o,
    output common_pkg::rgb332_t         border_o
);

    import common_pkg::*;

    logic        disp_en;
    rgb332_t     border;
    logic        ctrl_hit;
    logic        status_hit;
    logic [15:0] frame_cnt;
    word_t       ctrl_word;

    // pixel to cpu, frame pulse as a toggle
    logic        frame_tgl;
    logic        tgl_meta;
    logic        tgl_sync;
    logic        tgl_seen;

    // cpu to pixel, quasi-static control
    logic [8:0]  ctrl_meta;
    logic [8:0]  ctrl_sync;

    assign ctrl_hit   = reg_sel_i && (reg_addr_i[12:2] == 11'(`REG_CTRL >> 2));
    assign status_hit = reg_sel_i && (reg_addr_i[12:2] == 11'(`REG_STATUS >> 2));

    // lane 0 holds enable, lane 1 the border colour
    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            disp_en <= 1'b0;
            border  <= '0;
        end else if (ctrl_hit) begin
            if (wr_mask_i[0]) begin
                disp_en <= wr_data_i[0];
            end
            if (wr_mask_i[1]) begin
                border <= wr_data_i[15:8];
            end
        end
    end

    assign ctrl_word = {16'b0, border, 7'b0, disp_en};

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            rd_data_o <= '0;
        end else if (ctrl_hit) begin
            rd_data_o <= ctrl_word;
        end else if (status_hit) begin
            rd_data_o <= {16'b0, frame_cnt};
        end else begin
            rd_data_o <= '0;
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            frame_tgl <= 1'b0;
        end else if (frame_start_i) begin
            frame_tgl <= ~frame_tgl;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            tgl_meta  <= 1'b0;
            tgl_sync  <= 1'b0;
            tgl_seen  <= 1'b0;
            frame_cnt <= '0;
        end else begin
            tgl_meta <= frame_tgl;
            tgl_sync <= tgl_meta;
            tgl_seen <= tgl_sync;
            // one count per toggle edge
            if (tgl_sync != tgl_seen) begin
                frame_cnt <= frame_cnt + 16'd1;
            end
        end
    end

    // multi-bit settle is fine, fields change rarely
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            ctrl_meta <= '0;
            ctrl_sync <= '0;
        end else begin
            ctrl_meta <= {border, disp_en};
            ctrl_sync <= ctrl_meta;
        end
    end

    assign disp_en_o = ctrl_sync[0];
    assign border_o  = ctrl_sync[8:1];

endmodule

`default_nettype wire

// ==== pixel_pipe.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module pixel_pipe (
    input  wire logic                   pxl_clk_i,
    input  wire logic                   pxl_rst_i,
    input  wire common_pkg::coord_t     x_i,
    input  wire common_pkg::coord_t     y_i,
    input  wire logic                   active_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    input  wire logic                   disp_en_i,
    input  wire common_pkg::rgb332_t    border_i,
    output common_pkg::pxl_addr_t       ram_addr_o,
    input  wire common_pkg::byte_t      ram_data_i,
    output common_pkg::color4_t         vga_r_o,
    output common_pkg::color4_t         vga_g_o,
    output common_pkg::color4_t         vga_b_o,
    output logic                        vga_hsync_o,
    output logic                        vga_vsync_o,
    output logic                        vga_de_o
);

    import common_pkg::*;

    logic [3:0]             sx;
    logic [6:0]             px;
    logic [3:0]             sy;
    logic [5:0]             py;
    logic [`PIPE_DEPTH-1:0] hs_pipe;
    logic [`PIPE_DEPTH-1:0] vs_pipe;
    logic [`PIPE_DEPTH-1:0] act_pipe;
    rgb332_t                pix;

    // x/10 and x%10 tracked alongside the raster counters
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i || x_i == `H_TOTAL - 1) begin
            sx <= '0;
            px <= '0;
        end else if (sx == `PIC_SCALE - 1) begin
            sx <= '0;
            px <= px + 7'd1;
        end else begin
            sx <= sx + 4'd1;
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            sy <= '0;
            py <= '0;
        end else if (x_i == `H_TOTAL - 1) begin
            if (y_i == `V_TOTAL - 1) begin
                sy <= '0;
                py <= '0;
            end else if (sy == `PIC_SCALE - 1) begin
                sy <= '0;
                py <= py + 6'd1;
            end else begin
                sy <= sy + 4'd1;
            end
        end
    end

    // stage 1, framebuffer address
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            ram_addr_o <= '0;
        end else if (px < `PIC_W && py < `PIC_H) begin
            ram_addr_o <= pxl_addr_t'(py * `PIC_W + px);
        end else begin
            ram_addr_o <= '0;
        end
    end

    // sync and active delay, idle syncs high
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            hs_pipe  <= '1;
            vs_pipe  <= '1;
            act_pipe <= '0;
        end else begin
            hs_pipe  <= {hs_pipe[`PIPE_DEPTH-2:0], hsync_i};
            vs_pipe  <= {vs_pipe[`PIPE_DEPTH-2:0], vsync_i};
            act_pipe <= {act_pipe[`PIPE_DEPTH-2:0], active_i};
        end
    end

    assign vga_hsync_o = hs_pipe[`PIPE_DEPTH-1];
    assign vga_vsync_o = vs_pipe[`PIPE_DEPTH-1];
    assign vga_de_o    = act_pipe[`PIPE_DEPTH-1];

    assign pix = disp_en_i ? ram_data_i : border_i;

    // stage 3, rgb332 to 12-bit colour
    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i || !act_pipe[`PIPE_DEPTH-2]) begin
            vga_r_o <= '0;
            vga_g_o <= '0;
            vga_b_o <= '0;
        end else begin
            vga_r_o <= {pix[7:5], pix[7]};
            vga_g_o <= {pix[4:2], pix[4]};
            vga_b_o <= {pix[1:0], pix[1:0]};
        end
    end

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ns
`include "video_params.svh"
`default_nettype none

module vga_timing (
    input  wire logic               pxl_clk_i,
    input  wire logic               rst_i,
    output logic                    pxl_rst_o,
    output common_pkg::coord_t      x_o,
    output common_pkg::coord_t      y_o,
    output logic                    active_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    frame_start_o
);

    import common_pkg::*;

    logic   rst_meta;
    logic   rst_sync;
    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_last;

    // bring cpu-side reset into pixel domain
    always_ff @(posedge pxl_clk_i) begin
        rst_meta <= rst_i;
        rst_sync <= rst_meta;
    end

    assign pxl_rst_o = rst_sync;

    assign h_last = (h_cnt == `H_TOTAL - 1);

    always_ff @(posedge pxl_clk_i) begin
        if (rst_sync) begin
            h_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    // advances once per line
    always_ff @(posedge pxl_clk_i) begin
        if (rst_sync) begin
            v_cnt <= '0;
        end else if (h_last) begin
            if (v_cnt == `V_TOTAL - 1) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 10'd1;
            end
        end
    end

    assign x_o = h_cnt;
    assign y_o = v_cnt;

    assign active_o = (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);

    // both syncs active low
    assign hsync_o = !((h_cnt >= `H_ACTIVE + `H_FRONT) &&
                       (h_cnt < `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vsync_o = !((v_cnt >= `V_ACTIVE + `V_FRONT) &&
                       (v_cnt < `V_ACTIVE + `V_FRONT + `V_SYNC));

    // first pixel of the first vsync line
    assign frame_start_o = (v_cnt == `V_ACTIVE + `V_FRONT) && (h_cnt == '0);

endmodule

`default_nettype wire

// ==== video_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module video_ram (
    // cpu port
    input  wire logic                   cpu_clk_i,
    input  wire logic                   rst_i,
    input  wire common_pkg::word_t      cpu_addr_i,
    input  wire common_pkg::word_t      cpu_write_data_i,
    input  wire common_pkg::byte_mask_t cpu_write_mask_i,
    output common_pkg::word_t           cpu_read_data_o,

    // pixel port, read only
    input  wire logic                   pxl_clk_i,
    input  wire logic                   pxl_rst_i,
    input  wire common_pkg::pxl_addr_t  pxl_addr_i,
    output common_pkg::byte_t           pxl_data_o
);

    import common_pkg::*;

    byte_t     mem [0:4095];
    pxl_addr_t base;

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = '0;
        end
    end

    // word aligned, address bits 1:0 dropped
    assign base = {cpu_addr_i[11:2], 2'b00};

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            cpu_read_data_o <= '0;
        end else begin
            cpu_read_data_o <= {mem[base + 12'd3], mem[base + 12'd2],
                                mem[base + 12'd1], mem[base]};
        end

        for (int k = 0; k < 4; k++) begin
            if (cpu_write_mask_i[k]) begin
                mem[base + pxl_addr_t'(k)] <= cpu_write_data_i[8*k +: 8];
            end
        end
    end

    always_ff @(posedge pxl_clk_i) begin
        if (pxl_rst_i) begin
            pxl_data_o <= '0;
        end else begin
            pxl_data_o <= mem[pxl_addr_i];
        end
    end

endmodule

`default_nettype wire

// ==== common_pkg.sv ====
`default_nettype none

package common_pkg;

    // cpu address or data word
    typedef logic [31:0] word_t;

    typedef logic [7:0] byte_t;

    // bit k enables byte lane k
    typedef logic [3:0] byte_mask_t;

    // framebuffer byte address, 4 KiB
    typedef logic [11:0] pxl_addr_t;

    // red 7:5, green 4:2, blue 1:0
    typedef logic [7:0] rgb332_t;

    // one vga output channel
    typedef logic [3:0] color4_t;

    // raster x or y counter
    typedef logic [9:0] coord_t;

endpackage

`default_nettype wire

// ==== video_params.svh ====
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

`default_nettype none

// horizontal raster, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical raster, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// stored picture and its upscale factor
`define PIC_W 64
`define PIC_H 48
`define PIC_SCALE 10

// cpu address bit that selects the register block
`define REG_SEL_BIT 12
`define REG_CTRL 'h1000
`define REG_STATUS 'h1004

// counters to vga outputs, in pixel clocks
`define PIPE_DEPTH 3

`default_nettype wire

`endif
